// ==== vga_config.svh ====
// VGA text overlay configuration
// 800x600 raster timing, text window size and background colours
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// horizontal timing in pixels
`define VGA_H_ACTIVE 800
`define VGA_H_FP 40
`define VGA_H_SYNC 128
`define VGA_H_TOTAL 1056

// vertical timing in lines
`define VGA_V_ACTIVE 600
`define VGA_V_FP 1
`define VGA_V_SYNC 4
`define VGA_V_TOTAL 628

// text window, 16x4 cells of 8x16 pixels
`define RECT_WIDTH 128
`define RECT_HEIGHT 64

// background colours, 4:4:4
`define BG_BORDER_COLOR 12'hFFF
`define BG_FILL_COLOR 12'h448

`endif

// ==== vga_pkg.sv ====
// VGA pipeline types
// raster bus carried between the drawing stages and the text cell address
package vga_pkg;

	// 4:4:4 colour word
	typedef logic [11:0] rgb_t;

	// raster state of one pixel
	typedef struct packed {
		logic [10:0] hcount;
		logic [10:0] vcount;
		logic        hsync;
		logic        vsync;
		logic        hblnk;
		logic        vblnk;
		rgb_t        rgb;
	} vga_bus_t;

	// text cell address, row in the upper nibble
	typedef struct packed {
		logic [3:0] row;
		logic [3:0] col;
	} char_addr_t;

endpackage

// ==== vga_timing.sv ====
// VGA timing generator
// free-running raster counters with registered sync and blanking outputs
`include "vga_config.svh"

module vga_timing
	import vga_pkg::*;
(
	input  logic     pclk,
	input  logic     rst,
	output vga_bus_t bus_out
);

	localparam int HS_START = `VGA_H_ACTIVE + `VGA_H_FP;
	localparam int HS_END = HS_START + `VGA_H_SYNC;
	localparam int VS_START = `VGA_V_ACTIVE + `VGA_V_FP;
	localparam int VS_END = VS_START + `VGA_V_SYNC;

	logic [10:0] h_nxt;
	logic [10:0] v_nxt;

	// next raster position, vcount steps at the end of each line
	always_comb begin
		h_nxt = bus_out.hcount + 11'd1;
		v_nxt = bus_out.vcount;
		if (bus_out.hcount == 11'(`VGA_H_TOTAL - 1)) begin
			h_nxt = '0;
			if (bus_out.vcount == 11'(`VGA_V_TOTAL - 1)) begin
				v_nxt = '0;
			end else begin
				v_nxt = bus_out.vcount + 11'd1;
			end
		end
	end

	// sync and blanking decoded from the next position so they line up with the counters
	always_ff @(posedge pclk) begin
		if (rst) begin
			bus_out <= '0;
		end else begin
			bus_out.hcount <= h_nxt;
			bus_out.vcount <= v_nxt;
			bus_out.hblnk  <= (h_nxt >= 11'(`VGA_H_ACTIVE));
			bus_out.vblnk  <= (v_nxt >= 11'(`VGA_V_ACTIVE));
			bus_out.hsync  <= (h_nxt >= 11'(HS_START)) && (h_nxt < 11'(HS_END));
			bus_out.vsync  <= (v_nxt >= 11'(VS_START)) && (v_nxt < 11'(VS_END));
			bus_out.rgb    <= '0;
		end
	end

	// horizontal counter stays inside the line
	a_hcount_range: assert property (
		@(posedge pclk) disable iff (rst)
		bus_out.hcount < 11'(`VGA_H_TOTAL)
	);

endmodule

// ==== draw_background.sv ====
// background painter
// white frame border and fill colour, black in blanking, one cycle delay
`include "vga_config.svh"

module draw_background
	import vga_pkg::*;
(
	input  logic     pclk,
	input  logic     rst,
	input  vga_bus_t bus_in,
	output vga_bus_t bus_out
);

	logic edge_px;
	rgb_t rgb_nxt;

	always_comb begin
		edge_px = (bus_in.hcount == 11'd0) ||
			(bus_in.hcount == 11'(`VGA_H_ACTIVE - 1)) ||
			(bus_in.vcount == 11'd0) ||
			(bus_in.vcount == 11'(`VGA_V_ACTIVE - 1));
		if (bus_in.hblnk || bus_in.vblnk) begin
			rgb_nxt = '0;
		end else if (edge_px) begin
			rgb_nxt = `BG_BORDER_COLOR;
		end else begin
			rgb_nxt = `BG_FILL_COLOR;
		end
	end

	always_ff @(posedge pclk) begin
		if (rst) begin
			bus_out <= '0;
		end else begin
			bus_out     <= bus_in;
			bus_out.rgb <= rgb_nxt;
		end
	end

endmodule

// ==== text_rom.sv ====
// text message ROM
// maps a cell of the 16x4 window to a character code, one cycle latency
module text_rom
	import vga_pkg::*;
(
	input  logic       pclk,
	input  char_addr_t char_xy,
	output logic [7:0] char_code
);

	logic [7:0] code_nxt;

	// row 0 opens with a full block then a space, unlisted cells are blank
	always_comb begin
		case (char_xy)
			8'h00: code_nxt = 8'h7F;
			8'h01: code_nxt = 8'h20;
			8'h02: code_nxt = "V";
			8'h03: code_nxt = "G";
			8'h04: code_nxt = "A";
			8'h06: code_nxt = "8";
			8'h07: code_nxt = "0";
			8'h08: code_nxt = "0";
			8'h09: code_nxt = "X";
			8'h0A: code_nxt = "6";
			8'h0B: code_nxt = "0";
			8'h0C: code_nxt = "0";
			// row 1 reads VGA TEXT
			8'h14: code_nxt = "V";
			8'h15: code_nxt = "G";
			8'h16: code_nxt = "A";
			8'h18: code_nxt = "T";
			8'h19: code_nxt = "E";
			8'h1A: code_nxt = "X";
			8'h1B: code_nxt = "T";
			// row 2 reads 800 X 600
			8'h23: code_nxt = "8";
			8'h24: code_nxt = "0";
			8'h25: code_nxt = "0";
			8'h27: code_nxt = "X";
			8'h29: code_nxt = "6";
			8'h2A: code_nxt = "0";
			8'h2B: code_nxt = "0";
			default: code_nxt = 8'h20;
		endcase
	end

	always_ff @(posedge pclk) begin
		char_code <= code_nxt;
	end

endmodule

// ==== font_rom.sv ====
// font ROM
// 8-row glyphs drawn with doubled lines to fill the 8x16 cell
// one cycle latency, bit 7 is the leftmost pixel
module font_rom (
	input  logic       pclk,
	input  logic [7:0] char_code,
	input  logic [3:0] char_line,
	output logic [7:0] char_pixels
);

	logic [63:0] glyph;
	int          row_sel;

	// top glyph row sits in the upper byte
	always_comb begin
		case (char_code)
			8'h20: glyph = 64'h0000_0000_0000_0000;
			8'h7F: glyph = 64'hFFFF_FFFF_FFFF_FFFF;
			"0": glyph = 64'h3C66_6E76_6666_3C00;
			"6": glyph = 64'h3C60_607C_6666_3C00;
			"8": glyph = 64'h3C66_663C_6666_3C00;
			"A": glyph = 64'h183C_6666_7E66_6600;
			"E": glyph = 64'h7E60_607C_6060_7E00;
			"G": glyph = 64'h3C66_606E_6666_3C00;
			"T": glyph = 64'h7E18_1818_1818_1800;
			"V": glyph = 64'h6666_6666_663C_1800;
			"X": glyph = 64'h6666_3C18_3C66_6600;
			default: glyph = '0;
		endcase
		// two cell lines per glyph row
		row_sel = 7 - int'(char_line >> 1);
	end

	always_ff @(posedge pclk) begin
		char_pixels <= glyph[8 * row_sel +: 8];
	end

endmodule

// ==== draw_rect_char.sv ====
// text window overlay
// requests text and font ROM data for pixels inside the 128x64 window and
// paints set glyph bits in text_color, four cycles from bus_in to bus_out
`include "vga_config.svh"

module draw_rect_char
	import vga_pkg::*;
(
	input  logic       pclk,
	input  logic       rst,
	input  vga_bus_t   bus_in,
	input  logic [11:0] rect_x,
	input  logic [11:0] rect_y,
	input  rgb_t       text_color,
	input  logic [7:0] char_pixels,
	output vga_bus_t   bus_out,
	output char_addr_t char_xy,
	output logic [3:0] char_line
);

	// bus copies for stages 1 to 3, stage 4 is bus_out
	vga_bus_t    bus_d [3];

	logic [12:0] dx_in;
	logic [12:0] dy_in;
	logic        in_win;
	logic [12:0] dx_d3;
	logic [12:0] dy_d3;
	logic        in_win_d3;
	logic        pix_on;

	// position relative to the window origin, wraps high when left of or above it
	function automatic logic [12:0] rel_pos(input logic [10:0] pos, input logic [11:0] org);
		rel_pos = {2'b00, pos} - {1'b0, org};
	endfunction

	// window test on the incoming pixel
	always_comb begin
		dx_in  = rel_pos(bus_in.hcount, rect_x);
		dy_in  = rel_pos(bus_in.vcount, rect_y);
		in_win = (dx_in < 13'(`RECT_WIDTH)) && (dy_in < 13'(`RECT_HEIGHT));
	end

	// ROM request, addresses hold outside the window
	always_ff @(posedge pclk) begin
		if (rst) begin
			char_xy   <= '0;
			char_line <= '0;
		end else if (in_win) begin
			char_xy   <= '{row: dy_in[7:4], col: dx_in[6:3]};
			char_line <= dy_in[3:0];
		end
	end

	// delay line matching the text and font ROM latency
	always_ff @(posedge pclk) begin
		if (rst) begin
			bus_d[0] <= '0;
			bus_d[1] <= '0;
			bus_d[2] <= '0;
		end else begin
			bus_d[0] <= bus_in;
			bus_d[1] <= bus_d[0];
			bus_d[2] <= bus_d[1];
		end
	end

	// glyph row of this pixel is on char_pixels now, test the window again
	always_comb begin
		dx_d3     = rel_pos(bus_d[2].hcount, rect_x);
		dy_d3     = rel_pos(bus_d[2].vcount, rect_y);
		in_win_d3 = (dx_d3 < 13'(`RECT_WIDTH)) && (dy_d3 < 13'(`RECT_HEIGHT));
		pix_on    = in_win_d3 && char_pixels[3'd7 - dx_d3[2:0]] &&
			!bus_d[2].hblnk && !bus_d[2].vblnk;
	end

	always_ff @(posedge pclk) begin
		if (rst) begin
			bus_out <= '0;
		end else begin
			bus_out <= bus_d[2];
			if (pix_on) begin
				bus_out.rgb <= text_color;
			end
		end
	end

	// glyph line requested for a window pixel is the row within the cell of the stage 1 pixel
	a_char_line: assert property (
		@(posedge pclk) disable iff (rst)
		in_win |=> char_line == bus_d[0].vcount[3:0] - $past(rect_y[3:0])
	);

endmodule

// ==== vga_top.sv ====
// VGA text overlay top level
// timing -> background -> text window, with the text and font ROMs
module vga_top
	import vga_pkg::*;
(
	input  logic        pclk,
	input  logic        rst,
	input  logic [11:0] rect_x,
	input  logic [11:0] rect_y,
	input  rgb_t        text_color,
	output vga_bus_t    vga_out
);

	vga_bus_t   timing_bus;
	vga_bus_t   bg_bus;
	char_addr_t char_xy;
	logic [3:0] char_line;
	logic [7:0] char_code;
	logic [7:0] char_pixels;

	vga_timing u_timing (
		.pclk    (pclk),
		.rst     (rst),
		.bus_out (timing_bus)
	);

	draw_background u_background (
		.pclk    (pclk),
		.rst     (rst),
		.bus_in  (timing_bus),
		.bus_out (bg_bus)
	);

	draw_rect_char u_rect_char (
		.pclk        (pclk),
		.rst         (rst),
		.bus_in      (bg_bus),
		.rect_x      (rect_x),
		.rect_y      (rect_y),
		.text_color  (text_color),
		.char_pixels (char_pixels),
		.bus_out     (vga_out),
		.char_xy     (char_xy),
		.char_line   (char_line)
	);

	text_rom u_text_rom (
		.pclk      (pclk),
		.char_xy   (char_xy),
		.char_code (char_code)
	);

	font_rom u_font_rom (
		.pclk        (pclk),
		.char_code   (char_code),
		.char_line   (char_line),
		.char_pixels (char_pixels)
	);

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock and reset
// 4 ns pixel clock, reset held high for three rising edges
module tb_clk_gen (
	output logic pclk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		pclk = 1'b0;
		forever #2 pclk = ~pclk;
	end

	// release 1 ns after the third edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge pclk);
		#1 rst = 1'b0;
	end

endmodule

// ==== vga_top_tb.sv ====
// testbench for the VGA text overlay
// follows the raster position expected on vga_out and checks it with assertions
// over two frames, the second one with the window at an unaligned spot
`include "vga_config.svh"

module vga_top_tb
	import vga_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LATENCY = 5;
	localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
	localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 100;
	localparam int CELL_PIXELS = 8 * 16;
	localparam int HS_START = `VGA_H_ACTIVE + `VGA_H_FP;
	localparam int HS_END = HS_START + `VGA_H_SYNC;
	localparam int VS_START = `VGA_V_ACTIVE + `VGA_V_FP;
	localparam int VS_END = VS_START + `VGA_V_SYNC;
	localparam int SEED = 74643;
	// window moves while the output is deep in vertical blanking
	localparam int MOVE_LINE = `VGA_V_ACTIVE + 10;

	logic        pclk;
	logic        rst;
	logic [11:0] rect_x;
	logic [11:0] rect_y;
	rgb_t        text_color;
	vga_bus_t    vga_out;

	// expected position of the pixel now on vga_out
	logic [2:0]  lat_cnt = '0;
	logic        out_valid = 1'b0;
	logic [10:0] exp_h = '0;
	logic [10:0] exp_v = '0;
	int unsigned frames_done = 0;

	int          dx;
	int          dy;
	logic        exp_blank;
	logic        exp_in_win;
	logic        in_cell0;
	logic        in_cell1;
	rgb_t        exp_bg;

	int unsigned cycle_cnt = 0;
	int unsigned n_cell0 = 0;
	int unsigned n_cell1 = 0;
	int unsigned n_glyph = 0;
	int unsigned n_border = 0;

	tb_clk_gen u_clk_gen (
		.pclk (pclk),
		.rst  (rst)
	);

	vga_top u_dut (
		.pclk       (pclk),
		.rst        (rst),
		.rect_x     (rect_x),
		.rect_y     (rect_y),
		.text_color (text_color),
		.vga_out    (vga_out)
	);

	task automatic stop_failed();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	// any colour that cannot be mistaken for black or the background
	task automatic pick_text_color();
		rgb_t c;
		c = 12'($urandom);
		while (c == '0 || c == `BG_BORDER_COLOR || c == `BG_FILL_COLOR) begin
			c = 12'($urandom);
		end
		text_color = c;
	endtask

	task automatic wait_output_line(input int unsigned frame, input int line);
		do begin
			@(posedge pclk);
		end while (!(out_valid && frames_done == frame && int'(exp_v) == line && exp_h == '0));
	endtask

	task automatic wait_output_frames(input int unsigned frames);
		do begin
			@(posedge pclk);
		end while (frames_done != frames);
	endtask

	// raster counter starts with reset low, the output shows it LATENCY cycles later
	always @(posedge pclk) begin
		if (rst) begin
			lat_cnt     <= '0;
			out_valid   <= 1'b0;
			exp_h       <= '0;
			exp_v       <= '0;
			frames_done <= 0;
		end else if (!out_valid) begin
			lat_cnt   <= lat_cnt + 3'd1;
			out_valid <= (lat_cnt == 3'(LATENCY - 1));
		end else if (exp_h == 11'(`VGA_H_TOTAL - 1)) begin
			exp_h <= '0;
			if (exp_v == 11'(`VGA_V_TOTAL - 1)) begin
				exp_v       <= '0;
				frames_done <= frames_done + 1;
			end else begin
				exp_v <= exp_v + 11'd1;
			end
		end else begin
			exp_h <= exp_h + 11'd1;
		end
	end

	// expected colour classes of the output pixel
	always_comb begin
		dx         = int'(exp_h) - int'(rect_x);
		dy         = int'(exp_v) - int'(rect_y);
		exp_blank  = (exp_h >= 11'(`VGA_H_ACTIVE)) || (exp_v >= 11'(`VGA_V_ACTIVE));
		exp_in_win = !exp_blank && dx >= 0 && dx < `RECT_WIDTH &&
			dy >= 0 && dy < `RECT_HEIGHT;
		in_cell0   = exp_in_win && dx < 8 && dy < 16;
		in_cell1   = exp_in_win && dx >= 8 && dx < 16 && dy < 16;
		if (exp_blank) begin
			exp_bg = '0;
		end else if (exp_h == '0 || exp_v == '0 ||
			exp_h == 11'(`VGA_H_ACTIVE - 1) || exp_v == 11'(`VGA_V_ACTIVE - 1)) begin
			exp_bg = `BG_BORDER_COLOR;
		end else begin
			exp_bg = `BG_FILL_COLOR;
		end
	end

	a_hcount: assert property (@(posedge pclk) out_valid |-> vga_out.hcount == exp_h)
		else report_mismatch("hcount differs from the expected raster position");
	a_vcount: assert property (@(posedge pclk) out_valid |-> vga_out.vcount == exp_v)
		else report_mismatch("vcount differs from the expected raster position");
	a_hsync: assert property (@(posedge pclk) out_valid |->
		vga_out.hsync == (int'(exp_h) >= HS_START && int'(exp_h) < HS_END))
		else report_mismatch("hsync outside its window");
	a_vsync: assert property (@(posedge pclk) out_valid |->
		vga_out.vsync == (int'(exp_v) >= VS_START && int'(exp_v) < VS_END))
		else report_mismatch("vsync outside its window");
	a_hblnk: assert property (@(posedge pclk) out_valid |->
		vga_out.hblnk == (exp_h >= 11'(`VGA_H_ACTIVE)))
		else report_mismatch("hblnk wrong");
	a_vblnk: assert property (@(posedge pclk) out_valid |->
		vga_out.vblnk == (exp_v >= 11'(`VGA_V_ACTIVE)))
		else report_mismatch("vblnk wrong");
	a_blank_black: assert property (@(posedge pclk)
		out_valid && exp_blank |-> vga_out.rgb == '0)
		else report_mismatch("rgb not black during blanking");
	a_background: assert property (@(posedge pclk)
		out_valid && !exp_blank && !exp_in_win |-> vga_out.rgb == exp_bg)
		else report_mismatch("background colour wrong outside the text window");
	a_cell0: assert property (@(posedge pclk) out_valid && in_cell0 |->
		vga_out.rgb == text_color)
		else report_mismatch("full block cell not painted in text_color");
	a_cell1: assert property (@(posedge pclk) out_valid && in_cell1 |->
		vga_out.rgb == `BG_FILL_COLOR)
		else report_mismatch("space cell not showing the fill colour");
	a_window_colors: assert property (@(posedge pclk) out_valid && exp_in_win |->
		vga_out.rgb == text_color || vga_out.rgb == exp_bg)
		else report_mismatch("unexpected colour inside the text window");

	// how often the stimulus reached each kind of pixel
	always @(posedge pclk) begin
		if (out_valid) begin
			if (in_cell0) begin
				n_cell0 <= n_cell0 + 1;
			end
			if (in_cell1) begin
				n_cell1 <= n_cell1 + 1;
			end
			if (exp_in_win && !in_cell0 && vga_out.rgb == text_color) begin
				n_glyph <= n_glyph + 1;
			end
			if (!exp_blank && !exp_in_win && exp_bg == `BG_BORDER_COLOR) begin
				n_border <= n_border + 1;
			end
		end
	end

	always @(posedge pclk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		stop_failed();
	end

	initial begin
		void'($urandom(SEED));
		rect_x = 12'd200;
		rect_y = 12'd100;
		pick_text_color();

		wait_output_line(0, MOVE_LINE);
		#1;
		rect_x = 12'd333;
		rect_y = 12'd77;
		pick_text_color();

		wait_output_frames(2);
		if (n_cell0 == 2 * CELL_PIXELS && n_cell1 == 2 * CELL_PIXELS &&
			n_glyph > 0 && n_border > 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("not every check was reached: cell0 %0d, cell1 %0d, glyph %0d, border %0d",
				n_cell0, n_cell1, n_glyph, n_border);
			stop_failed();
		end
	end

endmodule

// ==== build.f ====
+incdir+.
vga_pkg.sv
vga_timing.sv
draw_background.sv
text_rom.sv
font_rom.sv
draw_rect_char.sv
vga_top.sv
tb_clk_gen.sv
vga_top_tb.sv

// ==== Makefile ====
SRCS := $(shell grep '\.sv$$' build.f) vga_config.svh

all: run

obj_dir/Vvga_top_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module vga_top_tb --Mdir obj_dir

run: obj_dir/Vvga_top_tb
	./obj_dir/Vvga_top_tb | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
